// ==== logic/snes_loader_pkg.sv ====
// Shared constants and types for the cartridge loader; imported by every loader block
`default_nettype none

package snes_loader_pkg;

	// ========================================
	// Widths
	// ========================================
	localparam int DL_ADDR_W = 25;
	localparam int DL_DATA_W = 16;
	localparam int MASK_W    = 24;
	localparam int LBA_W     = 32;

	// ========================================
	// Image layout
	// ========================================
	// Copier header sits in front of the real image
	localparam int COPIER_HEADER_BYTES = 512;

	// Stream addresses of the internal header size word
	localparam logic [DL_ADDR_W-1:0] LOROM_SIZE_ADDR =
		DL_ADDR_W'(32'h0000_7FD6 + COPIER_HEADER_BYTES);
	localparam logic [DL_ADDR_W-1:0] HIROM_SIZE_ADDR =
		DL_ADDR_W'(32'h0000_FFD6 + COPIER_HEADER_BYTES);
	localparam logic [DL_ADDR_W-1:0] EXHIROM_SIZE_ADDR =
		DL_ADDR_W'(32'h0040_FFD6 + COPIER_HEADER_BYTES);

	localparam logic [3:0] DEFAULT_ROM_SIZE_CODE = 4'd12;

	// 512-byte backup sectors
	localparam int SECTOR_ADDR_SHIFT = 9;

	// Download index reserved for cheat codes
	localparam logic [7:0] CODE_DOWNLOAD_INDEX = 8'hFF;

	// Header mode menu encodings
	localparam logic [2:0] HDR_AUTO    = 3'd0;
	localparam logic [2:0] HDR_NONE    = 3'd1;
	localparam logic [2:0] HDR_LOROM   = 3'd2;
	localparam logic [2:0] HDR_HIROM   = 3'd3;
	localparam logic [2:0] HDR_EXHIROM = 3'd4;

	// ========================================
	// Types
	// ========================================
	// One host download write, wr is a single-cycle strobe
	typedef struct packed {
		logic [DL_ADDR_W-1:0] addr;
		logic [DL_DATA_W-1:0] data;
		logic                 wr;
	} dl_write_t;

	// Menu settings, request bits are levels
	typedef struct packed {
		logic [2:0] header_mode;
		logic       autosave;
		logic       load_req;
		logic       save_req;
	} loader_cfg_t;

	// Cheat record, filled as words and read as fields
	typedef union packed {
		logic [7:0][15:0] word;
		struct packed {
			logic [31:0] flags;
			logic [31:0] address;
			logic [31:0] compare;
			logic [31:0] replace;
		} field;
	} cheat_code_u;

endpackage

`default_nettype wire

// ==== logic/download_decoder.sv ====
// Splits the host download into cartridge and cheat-code streams and flags cart start/end
`timescale 1ns/1ns
`default_nettype none

module download_decoder (
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       dl_active,
	input  logic [7:0] dl_index,
	output logic       cart_dl,
	output logic       code_dl,
	output logic       cart_start,
	output logic       cart_end
);
	import snes_loader_pkg::*;

	logic code_index;
	logic cart_dl_q;

	// All-ones index carries cheat codes, anything else is a cartridge
	assign code_index = (dl_index == CODE_DOWNLOAD_INDEX);
	assign cart_dl    = dl_active & ~code_index;
	assign code_dl    = dl_active & code_index;

	// Edge pulses land one cycle after the cart_dl transition
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			cart_dl_q  <= 1'b0;
			cart_start <= 1'b0;
			cart_end   <= 1'b0;
		end else begin
			cart_dl_q  <= cart_dl;
			cart_start <= cart_dl & ~cart_dl_q;
			cart_end   <= ~cart_dl & cart_dl_q;
		end
	end

endmodule

`default_nettype wire

// ==== logic/cart_header_detect.sv ====
// Picks mapper type, region and ROM/RAM address masks out of the cartridge download stream
`timescale 1ns/1ns
`default_nettype none

module cart_header_detect (
	input  logic                            clk_sys,
	input  logic                            reset,
	input  snes_loader_pkg::dl_write_t      dl,
	input  logic                            cart_dl,
	input  logic [2:0]                      header_mode,
	output logic [7:0]                      rom_type,
	output logic                            rom_region,
	output logic [snes_loader_pkg::MASK_W-1:0] rom_mask,
	output logic [snes_loader_pkg::MASK_W-1:0] ram_mask
);
	import snes_loader_pkg::*;

	logic                 cart_wr;
	logic [3:0]           rom_size;
	logic [3:0]           ram_size;
	logic [DL_ADDR_W-1:0] size_addr;
	logic                 size_forced;

	assign cart_wr = cart_dl & dl.wr;

	// Forced modes point at a fixed internal header location
	always_comb begin
		size_forced = 1'b1;
		case (header_mode)
			HDR_LOROM:   size_addr = LOROM_SIZE_ADDR;
			HDR_HIROM:   size_addr = HIROM_SIZE_ADDR;
			HDR_EXHIROM: size_addr = EXHIROM_SIZE_ADDR;
			default: begin
				size_addr   = LOROM_SIZE_ADDR;
				size_forced = 1'b0;
			end
		endcase
	end

	// ========================================
	// Header field capture
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			rom_size   <= DEFAULT_ROM_SIZE_CODE;
			ram_size   <= 4'd0;
			rom_type   <= 8'd0;
			rom_region <= 1'b0;
		end else if (cart_wr) begin
			if (dl.addr == '0) begin
				rom_size <= DEFAULT_ROM_SIZE_CODE;
				ram_size <= 4'd0;
				// Copier header packs both size codes in its first byte
				if (header_mode == HDR_AUTO && dl.data[7:0] != 8'd0) begin
					ram_size <= dl.data[7:4];
					rom_size <= dl.data[3:0];
				end

				case (header_mode)
					HDR_NONE,
					HDR_LOROM:   rom_type <= 8'd0;
					HDR_HIROM:   rom_type <= 8'd1;
					HDR_EXHIROM: rom_type <= 8'd2;
					default:     rom_type <= dl.data[15:8];
				endcase
			end

			if (dl.addr == DL_ADDR_W'(2)) begin
				rom_region <= dl.data[8];
			end

			// Internal header wins over the defaults when the mode is forced
			if (size_forced) begin
				if (dl.addr == size_addr) begin
					rom_size <= dl.data[11:8];
				end
				if (dl.addr == size_addr + DL_ADDR_W'(2)) begin
					ram_size <= dl.data[3:0];
				end
			end
		end
	end

	// ========================================
	// Size code to address mask
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			rom_mask <= '0;
			ram_mask <= '0;
		end else begin
			rom_mask <= (MASK_W'(1024) << rom_size) - MASK_W'(1);
			// Size code 0 means no backup RAM at all
			ram_mask <= (ram_size != 4'd0) ? (MASK_W'(1024) << ram_size) - MASK_W'(1) : '0;
		end
	end

endmodule

`default_nettype wire

// ==== logic/cheat_code_assembler.sv ====
// Gathers eight code-download words into one cheat record and strobes it out
`timescale 1ns/1ns
`default_nettype none

module cheat_code_assembler (
	input  logic                         clk_sys,
	input  logic                         reset,
	input  snes_loader_pkg::dl_write_t   dl,
	input  logic                         code_dl,
	input  logic                         cart_dl,
	output snes_loader_pkg::cheat_code_u cheat,
	output logic                         cheat_valid,
	output logic                         cheat_clear
);

	logic       code_wr;
	logic [2:0] word_sel;

	// Only even byte addresses carry a word
	assign code_wr = code_dl & dl.wr & ~dl.addr[0];

	// Field 0 (flags) is the top pair of words, field 3 (replace) the bottom pair
	// Bit 1 picks the upper half of the field
	assign word_sel = {~dl.addr[3:2], dl.addr[1]};

	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			cheat.word[word_sel] <= dl.data;
		end
	end

	// Record is complete after the replace top word at offset 14
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			cheat_valid <= 1'b0;
		end else begin
			cheat_valid <= code_wr & (dl.addr[3:0] == 4'd14);
		end
	end

	// New cartridge or a fresh code list wipes the stored cheats
	assign cheat_clear = cart_dl | (code_wr & (dl.addr == '0));

endmodule

`default_nettype wire

// ==== logic/backup_sector_sequencer.sv ====
// Runs backup RAM sector load/save transfers against the mounted save image
`timescale 1ns/1ns
`default_nettype none

module backup_sector_sequencer (
	input  logic                                clk_sys,
	input  logic                                reset,
	input  snes_loader_pkg::loader_cfg_t        cfg,
	input  logic [snes_loader_pkg::MASK_W-1:0]  ram_mask,
	input  logic                                cart_dl,
	input  logic                                cart_start,
	input  logic                                cart_end,
	input  logic                                img_mounted,
	input  logic                                img_readonly,
	input  logic [63:0]                         img_size,
	input  logic                                osd_open,
	input  logic                                bsram_write,
	input  logic                                sd_ack,
	output logic                                sd_rd,
	output logic                                sd_wr,
	output logic [snes_loader_pkg::LBA_W-1:0]   sd_lba,
	output logic                                backup_enabled,
	output logic                                backup_busy,
	output logic                                backup_loading,
	output logic                                led_user
);
	import snes_loader_pkg::*;

	logic             pending;
	logic             save_req;
	logic             load_q;
	logic             save_q;
	logic             ack_q;
	logic             load_start;
	logic             save_start;
	logic             auto_start;
	logic             seq_start;
	logic             seq_load;
	logic [LBA_W-1:0] last_lba;

	// Autosave fires when the menu opens with unsaved writes
	assign save_req = cfg.save_req | (pending & osd_open & cfg.autosave);

	assign load_start = cfg.load_req & ~load_q & backup_enabled;
	assign save_start = save_req & ~save_q & backup_enabled;
	assign auto_start = cart_end & (img_size != 64'd0) & backup_enabled;
	assign seq_start  = ~backup_busy & (load_start | save_start | auto_start);
	assign seq_load   = load_start | auto_start;

	// Last sector index covered by the backup RAM
	assign last_lba = LBA_W'(ram_mask >> SECTOR_ADDR_SHIFT);

	assign led_user = cart_dl | (cfg.autosave & pending);

	// ========================================
	// Backup enable and dirty tracking
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			backup_enabled <= 1'b0;
			pending        <= 1'b0;
		end else begin
			if (cart_start) begin
				backup_enabled <= 1'b0;
			end
			// Save image is always mounted by the end of the download
			if (cart_dl & img_mounted & ~img_readonly) begin
				backup_enabled <= (ram_mask != '0);
			end

			if (backup_enabled & ~osd_open & bsram_write) begin
				pending <= 1'b1;
			end else if (seq_start) begin
				pending <= 1'b0;
			end
		end
	end

	// ========================================
	// Sector transfer sequence
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			load_q         <= 1'b0;
			save_q         <= 1'b0;
			ack_q          <= 1'b0;
			sd_rd          <= 1'b0;
			sd_wr          <= 1'b0;
			sd_lba         <= '0;
			backup_busy    <= 1'b0;
			backup_loading <= 1'b0;
		end else begin
			load_q <= cfg.load_req;
			save_q <= save_req;
			ack_q  <= sd_ack;

			// Host took the request
			if (sd_ack & ~ack_q) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end

			if (seq_start) begin
				backup_busy    <= 1'b1;
				backup_loading <= seq_load;
				sd_lba         <= '0;
				sd_rd          <= seq_load;
				sd_wr          <= ~seq_load;
			end else if (backup_busy & ~sd_ack & ack_q) begin
				// Sector done, finish or move on
				if (sd_lba >= last_lba) begin
					backup_busy    <= 1'b0;
					backup_loading <= 1'b0;
				end else begin
					sd_lba <= sd_lba + LBA_W'(1);
					sd_rd  <= backup_loading;
					sd_wr  <= ~backup_loading;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/snes_loader_top.sv ====
// Loader top level: download decode, header detect, cheat assembly and backup sequencing
`timescale 1ns/1ns
`default_nettype none

module snes_loader_top (
	input  logic                               clk_sys,
	input  logic                               reset,
	input  snes_loader_pkg::dl_write_t         dl,
	input  logic                               dl_active,
	input  logic [7:0]                         dl_index,
	input  snes_loader_pkg::loader_cfg_t       cfg,
	input  logic                               bsram_write,
	input  logic                               osd_open,
	input  logic                               img_mounted,
	input  logic                               img_readonly,
	input  logic [63:0]                        img_size,
	input  logic                               sd_ack,
	output logic [7:0]                         rom_type,
	output logic                               rom_region,
	output logic [snes_loader_pkg::MASK_W-1:0] rom_mask,
	output logic [snes_loader_pkg::MASK_W-1:0] ram_mask,
	output snes_loader_pkg::cheat_code_u       cheat,
	output logic                               cheat_valid,
	output logic                               cheat_clear,
	output logic                               sd_rd,
	output logic                               sd_wr,
	output logic [snes_loader_pkg::LBA_W-1:0]  sd_lba,
	output logic                               backup_enabled,
	output logic                               backup_busy,
	output logic                               backup_loading,
	output logic                               led_user
);

	logic cart_dl;
	logic code_dl;
	logic cart_start;
	logic cart_end;

	download_decoder u_decoder (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.dl_active  (dl_active),
		.dl_index   (dl_index),
		.cart_dl    (cart_dl),
		.code_dl    (code_dl),
		.cart_start (cart_start),
		.cart_end   (cart_end)
	);

	cart_header_detect u_header (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dl          (dl),
		.cart_dl     (cart_dl),
		.header_mode (cfg.header_mode),
		.rom_type    (rom_type),
		.rom_region  (rom_region),
		.rom_mask    (rom_mask),
		.ram_mask    (ram_mask)
	);

	cheat_code_assembler u_cheat (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dl          (dl),
		.code_dl     (code_dl),
		.cart_dl     (cart_dl),
		.cheat       (cheat),
		.cheat_valid (cheat_valid),
		.cheat_clear (cheat_clear)
	);

	backup_sector_sequencer u_backup (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.cfg            (cfg),
		.ram_mask       (ram_mask),
		.cart_dl        (cart_dl),
		.cart_start     (cart_start),
		.cart_end       (cart_end),
		.img_mounted    (img_mounted),
		.img_readonly   (img_readonly),
		.img_size       (img_size),
		.osd_open       (osd_open),
		.bsram_write    (bsram_write),
		.sd_ack         (sd_ack),
		.sd_rd          (sd_rd),
		.sd_wr          (sd_wr),
		.sd_lba         (sd_lba),
		.backup_enabled (backup_enabled),
		.backup_busy    (backup_busy),
		.backup_loading (backup_loading),
		.led_user       (led_user)
	);

endmodule

`default_nettype wire

// ==== dv/snes_loader_tests.svh ====
// Directed loader tests and download helpers; included inside the testbench module body
`ifndef SNES_LOADER_TESTS_SVH
`define SNES_LOADER_TESTS_SVH

// ========================================
// Reporting and stimulus helpers
// ========================================
task automatic report_mismatch(input string msg);
	mismatch_count++;
	$display("** Error at %0t ns: %s", $time, msg);
endtask

task automatic report_failure(input string msg);
	failure_count++;
	$display("Failure at %0t ns: %s", $time, msg);
endtask

task automatic start_download(input logic [7:0] index);
	@(negedge clk_sys);
	dl_index  = index;
	dl_active = 1'b1;
endtask

task automatic finish_download();
	@(negedge clk_sys);
	dl_active = 1'b0;
endtask

// One write strobe released on the next falling edge
task automatic write_word(input logic [DL_ADDR_W-1:0] addr, input logic [15:0] data);
	@(negedge clk_sys);
	dl.addr = addr;
	dl.data = data;
	dl.wr   = 1'b1;
	@(negedge clk_sys);
	dl.wr = 1'b0;
endtask

task automatic write_filler(input int first, input int count);
	int a;
	for (a = 0; a < count; a++) begin
		write_word(DL_ADDR_W'(first + 2 * a), 16'($urandom()));
	end
endtask

task automatic wait_busy(input logic level, input string what);
	int n;
	n = 0;
	while (backup_busy !== level && n < 200) begin
		@(negedge clk_sys);
		n++;
	end
	if (backup_busy !== level) begin
		report_failure({"timed out waiting for ", what});
	end
endtask

// 2 KB of backup RAM is four 512-byte sectors numbered from 0
task automatic check_sectors(input int base, input logic expect_wr);
	int i;
	if (lba_log.size() != base + 4) begin
		report_mismatch($sformatf("sector count %0d, expected 4", lba_log.size() - base));
	end
	for (i = 0; i < 4 && base + i < lba_log.size(); i++) begin
		if (lba_log[base + i] !== LBA_W'(i)) begin
			report_mismatch($sformatf("sd_lba %0d, expected %0d", lba_log[base + i], i));
		end
		if (wr_log[base + i] !== expect_wr) begin
			report_mismatch($sformatf("sector %0d direction wr=%b", i, wr_log[base + i]));
		end
	end
endtask

// ========================================
// Header detection
// ========================================
task automatic test_auto_header();
	@(negedge clk_sys);
	cfg.header_mode = HDR_AUTO;
	start_download(8'd1);
	// Copier byte 0x1A packs RAM code 1 and ROM code 10
	write_word('0, 16'h351A);
	write_word(DL_ADDR_W'(2), 16'($urandom()) | 16'h0100);
	write_filler(4, 4);
	finish_download();
	repeat (2) @(negedge clk_sys);
	if (rom_type !== 8'h35) begin
		report_mismatch($sformatf("auto rom_type %h, expected 35", rom_type));
	end
	if (rom_region !== 1'b1) begin
		report_mismatch("auto rom_region low, expected high");
	end
	if (rom_mask !== 24'h0FFFFF) begin
		report_mismatch($sformatf("auto rom_mask %h, expected 0fffff", rom_mask));
	end
	if (ram_mask !== 24'h0007FF) begin
		report_mismatch($sformatf("auto ram_mask %h, expected 0007ff", ram_mask));
	end
endtask

task automatic test_forced_lorom();
	@(negedge clk_sys);
	cfg.header_mode = HDR_LOROM;
	start_download(8'd1);
	write_word('0, 16'h351A);
	write_word(DL_ADDR_W'(2), 16'($urandom()));
	write_word(LOROM_SIZE_ADDR, {8'h0B, 8'($urandom())});
	write_word(LOROM_SIZE_ADDR + DL_ADDR_W'(2), {8'($urandom()), 8'h03});
	finish_download();
	repeat (2) @(negedge clk_sys);
	if (rom_type !== 8'h00) begin
		report_mismatch($sformatf("lorom rom_type %h, expected 00", rom_type));
	end
	if (rom_mask !== 24'h1FFFFF) begin
		report_mismatch($sformatf("lorom rom_mask %h, expected 1fffff", rom_mask));
	end
	if (ram_mask !== 24'h001FFF) begin
		report_mismatch($sformatf("lorom ram_mask %h, expected 001fff", ram_mask));
	end
	cfg.header_mode = HDR_AUTO;
endtask

// ========================================
// Cheat record
// ========================================
task automatic test_cheat_record();
	logic [15:0] words [8];
	logic [31:0] expect_field [4];
	int          i;
	int          n;
	int          pulses;
	for (i = 0; i < 8; i++) begin
		words[i] = 16'($urandom());
	end
	// Offset 4*f + 2*h holds half h of field f with the upper half on top
	for (i = 0; i < 4; i++) begin
		expect_field[i] = {words[2 * i + 1], words[2 * i]};
	end
	pulses = 0;
	start_download(CODE_DOWNLOAD_INDEX);
	@(negedge clk_sys);
	dl.addr = '0;
	dl.data = words[0];
	dl.wr   = 1'b1;
	#1;
	if (cheat_clear !== 1'b1) begin
		report_mismatch("cheat_clear low on the address-0 code write");
	end
	@(negedge clk_sys);
	dl.wr = 1'b0;
	for (i = 1; i < 8; i++) begin
		if (cheat_valid === 1'b1) begin
			pulses++;
		end
		write_word(DL_ADDR_W'(2 * i), words[i]);
	end
	n = 0;
	while (cheat_valid !== 1'b1 && n < 8) begin
		@(negedge clk_sys);
		n++;
	end
	if (cheat_valid !== 1'b1) begin
		report_failure("cheat_valid never pulsed after the last code word");
	end else begin
		pulses++;
		if (cheat.field.flags !== expect_field[0]) begin
			report_mismatch($sformatf("flags %h, expected %h", cheat.field.flags,
				expect_field[0]));
		end
		if (cheat.field.address !== expect_field[1]) begin
			report_mismatch($sformatf("address %h, expected %h", cheat.field.address,
				expect_field[1]));
		end
		if (cheat.field.compare !== expect_field[2]) begin
			report_mismatch($sformatf("compare %h, expected %h", cheat.field.compare,
				expect_field[2]));
		end
		if (cheat.field.replace !== expect_field[3]) begin
			report_mismatch($sformatf("replace %h, expected %h", cheat.field.replace,
				expect_field[3]));
		end
		@(negedge clk_sys);
		if (cheat_valid !== 1'b0) begin
			report_mismatch("cheat_valid high for more than one cycle");
		end
	end
	if (pulses != 1) begin
		report_mismatch($sformatf("%0d cheat_valid pulses, expected 1", pulses));
	end
	finish_download();
endtask

// ========================================
// Backup sequencing
// ========================================
task automatic test_autoload();
	int base;
	base = lba_log.size();
	@(negedge clk_sys);
	img_mounted  = 1'b1;
	img_readonly = 1'b0;
	img_size     = 64'd2048;
	start_download(8'd1);
	write_word('0, 16'h351A);
	write_filler(2, 4);
	if (backup_enabled !== 1'b1) begin
		report_mismatch("backup_enabled low during a writable download");
	end
	finish_download();
	wait_busy(1'b1, "autoload to start");
	if (backup_loading !== 1'b1) begin
		report_mismatch("backup_loading low during the autoload");
	end
	wait_busy(1'b0, "autoload to finish");
	if (backup_loading !== 1'b0) begin
		report_mismatch("backup_loading still high after the autoload");
	end
	check_sectors(base, 1'b0);
endtask

task automatic test_autosave();
	int base;
	base = lba_log.size();
	@(negedge clk_sys);
	cfg.autosave = 1'b1;
	bsram_write  = 1'b1;
	@(negedge clk_sys);
	bsram_write = 1'b0;
	if (led_user !== 1'b1) begin
		report_mismatch("led_user low with an unsaved backup write");
	end
	@(negedge clk_sys);
	osd_open = 1'b1;
	wait_busy(1'b1, "autosave to start");
	if (backup_loading !== 1'b0) begin
		report_mismatch("backup_loading high during the autosave");
	end
	wait_busy(1'b0, "autosave to finish");
	check_sectors(base, 1'b1);
	if (led_user !== 1'b0) begin
		report_mismatch("led_user still high after the autosave");
	end
	osd_open = 1'b0;
endtask

task automatic test_readonly_image();
	int   base;
	int   n;
	logic seen_rd;
	@(negedge clk_sys);
	cfg.autosave = 1'b0;
	img_readonly = 1'b1;
	base         = lba_log.size();
	start_download(8'd1);
	write_word('0, 16'h351A);
	write_filler(2, 4);
	finish_download();
	repeat (2) @(negedge clk_sys);
	if (backup_enabled !== 1'b0) begin
		report_mismatch("backup_enabled high with a read-only image");
	end
	cfg.load_req = 1'b1;
	@(negedge clk_sys);
	cfg.load_req = 1'b0;
	seen_rd = 1'b0;
	n = 0;
	while (n < 40) begin
		if (sd_rd === 1'b1) begin
			seen_rd = 1'b1;
		end
		@(negedge clk_sys);
		n++;
	end
	if (seen_rd || lba_log.size() != base) begin
		report_mismatch("sd_rd requested although the image is read-only");
	end
endtask

`endif

// ==== dv/snes_loader_tb.sv ====
// Testbench top for the cartridge loader; run it with the file list to drive all directed tests
`timescale 1ns/1ns
`default_nettype none

module snes_loader_tb;
	import snes_loader_pkg::*;

	logic               clk_sys = 1'b0;
	logic               reset;
	dl_write_t          dl;
	logic               dl_active;
	logic [7:0]         dl_index;
	loader_cfg_t        cfg;
	logic               bsram_write;
	logic               osd_open;
	logic               img_mounted;
	logic               img_readonly;
	logic [63:0]        img_size;
	logic               sd_ack = 1'b0;
	logic [7:0]         rom_type;
	logic               rom_region;
	logic [MASK_W-1:0]  rom_mask;
	logic [MASK_W-1:0]  ram_mask;
	cheat_code_u        cheat;
	logic               cheat_valid;
	logic               cheat_clear;
	logic               sd_rd;
	logic               sd_wr;
	logic [LBA_W-1:0]   sd_lba;
	logic               backup_enabled;
	logic               backup_busy;
	logic               backup_loading;
	logic               led_user;

	int                 mismatch_count = 0;
	int                 failure_count = 0;
	logic [LBA_W-1:0]   lba_log[$];
	logic               wr_log[$];
	int unsigned        ack_delay;

	always #20 clk_sys = ~clk_sys;

	snes_loader_top dut (.*);

	// ========================================
	// Host side of the sector handshake
	// ========================================
	// Each request is logged, then acked and released after random delays
	always begin
		@(negedge clk_sys);
		if (sd_rd === 1'b1 || sd_wr === 1'b1) begin
			lba_log.push_back(sd_lba);
			wr_log.push_back(sd_wr);
			ack_delay = $urandom_range(4, 1);
			repeat (ack_delay) @(negedge clk_sys);
			sd_ack = 1'b1;
			ack_delay = $urandom_range(4, 1);
			repeat (ack_delay) @(negedge clk_sys);
			sd_ack = 1'b0;
		end
	end

	`include "snes_loader_tests.svh"

	initial begin
		reset        = 1'b0;
		dl           = '0;
		dl_active    = 1'b0;
		dl_index     = 8'd0;
		cfg          = '0;
		bsram_write  = 1'b0;
		osd_open     = 1'b0;
		img_mounted  = 1'b0;
		img_readonly = 1'b0;
		img_size     = 64'd0;
		void'($urandom(32'hc34f));
		repeat (2) @(negedge clk_sys);
		reset = 1'b1;

		test_auto_header();
		test_forced_lorom();
		test_cheat_record();
		test_autoload();
		test_autosave();
		test_readonly_image();

		$display("Loader run done: %0d value errors, %0d other failures",
			mismatch_count, failure_count);
		if (mismatch_count == 0 && failure_count == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== snes_loader_top.f ====
+incdir+dv
logic/snes_loader_pkg.sv
logic/download_decoder.sv
logic/cart_header_detect.sv
logic/cheat_code_assembler.sv
logic/backup_sector_sequencer.sv
logic/snes_loader_top.sv
dv/snes_loader_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
	--top-module snes_loader_tb \
	-f snes_loader_top.f

sim_output=$(./obj_dir/Vsnes_loader_tb)
echo "$sim_output"

if echo "$sim_output" | grep -qx "TB PASSED"; then
	exit 0
fi
exit 1
